// File: verilog.f
design/rp_bus_pkg.sv
design/rp_analog_pkg.sv
design/sys_bus_decoder.sv
design/housekeeping.sv
design/adc_frontend.sv
design/output_router.sv
design/dac_backend.sv
design/rp_top.sv
tests/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of tb_top; pass only if the log holds the pass line
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f verilog.f
status=0
./obj_dir/Vtb_top > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -eq 0 ] && grep -qx "No errors" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: tests/tb_top.sv
// bus tasks assume one access at a time; checks are concurrent assertions armed by chk_* flags
`timescale 1ns/1ps

module tb_top;

  localparam int BUS_TMO = 20;  // cycles allowed for an ack

  logic                                adc_clk;
  logic                                rst_i;
  logic [rp_bus_pkg::BUS_AW-1:0]       sys_addr_i;
  logic [rp_bus_pkg::BUS_DW-1:0]       sys_wdata_i;
  logic                                sys_wen_i;
  logic                                sys_ren_i;
  logic [rp_bus_pkg::BUS_DW-1:0]       sys_rdata_o;
  logic                                sys_ack_o;
  logic                                sys_err_o;
  logic [rp_analog_pkg::SMP_W-1:0]     adc_dat_a_i;
  logic [rp_analog_pkg::SMP_W-1:0]     adc_dat_b_i;
  logic [rp_analog_pkg::SMP_W-1:0]     dac_dat_a_o;
  logic [rp_analog_pkg::SMP_W-1:0]     dac_dat_b_o;
  logic [7:0]                          led_o;

  // expectations and check enables
  logic [rp_bus_pkg::BUS_DW-1:0] exp_rd;
  logic                          exp_err;
  logic [7:0]                    exp_led;
  logic chk_data, chk_led, chk_idle, chk_pass, chk_sat, chk_loop;
  logic adc_run;                    // random pins on
  logic [31:0] rng;
  int ofs_a, ofs_b, k_val;
  int err_cnt, tmo_cnt;

  rp_top DUT (.*);

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // pin code counts down from 0x1FFF at zero
  function automatic int code_value(input logic [rp_analog_pkg::SMP_W-1:0] code);
    return 8191 - int'(code);
  endfunction

  function automatic logic [rp_analog_pkg::SMP_W-1:0] value_code(input int v);
    return 14'(8191 - v);
  endfunction

  // raw adc code plus offset, clamped, back to pin code
  function automatic logic [rp_analog_pkg::SMP_W-1:0] sat_code(
    input logic [rp_analog_pkg::SMP_W-1:0] raw, input int ofs);
    int v;
    v = code_value(raw) + ofs;
    if (v > int'(rp_analog_pkg::SMP_MAX))
      v = int'(rp_analog_pkg::SMP_MAX);
    else if (v < int'(rp_analog_pkg::SMP_MIN))
      v = int'(rp_analog_pkg::SMP_MIN);
    return value_code(v);
  endfunction

  function automatic logic [31:0] reg_addr(input rp_bus_pkg::region_e r, input logic [19:0] ofs);
    return {9'd0, r, ofs};
  endfunction

  initial
  begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;  // 100 ns period
  end

  // random adc pins with a new code every cycle
  always @(posedge adc_clk)
  begin
    #1;
    if (adc_run)
    begin
      rng = lcg_next(rng);
      adc_dat_a_i = rng[29:16];
      adc_dat_b_i = rng[15:2];
    end
  end

  // one strobe cycle, then wait for ack; entered and left 1 ns after an edge
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    int  n;
    logic got;
    n = 0;
    got = 1'b0;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    while (!got && n < BUS_TMO)
    begin
      @(negedge adc_clk);
      got = sys_ack_o;  // mid-cycle sample
      @(posedge adc_clk);
      #1;
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      n++;
    end
    if (!got)
    begin
      tmo_cnt++;
      $display("bus access to %h got no ack within %0d cycles", addr, BUS_TMO);
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    bus_access(1'b1, addr, data);
  endtask

  // error reads are not checked for data
  task automatic read_expect(input logic [31:0] addr, input logic [31:0] data, input logic err);
    exp_rd   = data;
    exp_err  = err;
    chk_data = ~err;
    bus_access(1'b0, addr, 32'd0);
    chk_data = 1'b0;
    exp_err  = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
    #1;
  endtask

  task automatic test_done(input int num, input string name);
    $display("test %0d %s finished, %0d failed checks so far", num, name, err_cnt);
  endtask

  //////////////////////////////
  // assertions
  //////////////////////////////
  a_err: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_ack_o |-> sys_err_o == exp_err)
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: sys_err_o=%b, expected %b", $time, sys_err_o, exp_err);
    end

  a_rdata: assert property (@(posedge adc_clk) disable iff (rst_i)
    (sys_ack_o && chk_data) |-> sys_rdata_o == exp_rd)
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: read %h, expected %h", $time, sys_rdata_o, exp_rd);
    end

  // slave regions answer one cycle later
  a_ack_next: assert property (@(posedge adc_clk) disable iff (rst_i)
    ((sys_wen_i || sys_ren_i) && (sys_addr_i[22:20] == 3'd0 || sys_addr_i[22:20] == 3'd3))
    |=> sys_ack_o)
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: slave ack missing", $time);
    end

  // empty region 1 answers in the same cycle with zero
  a_empty: assert property (@(posedge adc_clk) disable iff (rst_i)
    (sys_ren_i && sys_addr_i[22:20] == 3'd1) |-> (sys_ack_o && sys_rdata_o == 32'd0 && !sys_err_o))
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: region 1 answer wrong", $time);
    end

  a_led: assert property (@(posedge adc_clk) disable iff (rst_i)
    chk_led |-> led_o == exp_led)
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: led_o=%h, expected %h", $time, led_o, exp_led);
    end

  a_idle: assert property (@(posedge adc_clk) disable iff (rst_i)
    chk_idle |-> (dac_dat_a_o == 14'h1FFF && dac_dat_b_o == 14'h1FFF))
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: dac not at zero code", $time);
    end

  // 3 cycles pin to pin where the two conversions cancel
  a_pass: assert property (@(posedge adc_clk) disable iff (rst_i)
    chk_pass |-> dac_dat_a_o == $past(adc_dat_a_i, 3))
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: dac a=%h, expected %h", $time, dac_dat_a_o,
               $past(adc_dat_a_i, 3));
    end

  a_sat: assert property (@(posedge adc_clk) disable iff (rst_i)
    chk_sat |-> (dac_dat_a_o == sat_code($past(adc_dat_a_i, 3), ofs_a) &&
                 dac_dat_b_o == sat_code($past(adc_dat_b_i, 3), ofs_b)))
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: saturated sum mismatch a=%h b=%h", $time,
               dac_dat_a_o, dac_dat_b_o);
    end

  // a has positive, b negative offset; a wrap would reverse the order
  a_nowrap: assert property (@(posedge adc_clk) disable iff (rst_i)
    chk_sat |-> (code_value(dac_dat_a_o) >= code_value($past(adc_dat_a_i, 3)) &&
                 code_value(dac_dat_b_o) <= code_value($past(adc_dat_b_i, 3))))
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: output wrapped past the limits", $time);
    end

  a_loop: assert property (@(posedge adc_clk) disable iff (rst_i)
    chk_loop |-> (dac_dat_a_o == value_code(k_val) && dac_dat_b_o == value_code(k_val)))
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t: loop a=%h b=%h, expected %h", $time, dac_dat_a_o, dac_dat_b_o,
               value_code(k_val));
    end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial
  begin
    rst_i = 1'b1;
    sys_addr_i = '0;
    sys_wdata_i = '0;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    {chk_data, chk_led, chk_idle, chk_pass, chk_sat, chk_loop} = '0;
    exp_rd = '0;
    exp_err = 1'b0;
    exp_led = 8'h00;
    adc_run = 1'b0;
    rng = 32'h5f94;  // lcg seed
    ofs_a = 0;
    ofs_b = 0;
    k_val = -1234;
    err_cnt = 0;
    tmo_cnt = 0;
    repeat (5) @(posedge adc_clk);
    #1;
    rst_i = 1'b0;

    chk_led = 1'b1;
    chk_idle = 1'b1;
    wait_cycles(3);
    read_expect(reg_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_ID_OFS), rp_bus_pkg::HK_ID_VALUE, 1'b0);
    chk_idle = 1'b0;
    test_done(1, "reset state");

    chk_led = 1'b0;  // led moves at the ack edge
    write_reg(reg_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_LED_OFS), 32'h0000_00A5);
    exp_led = 8'hA5;
    chk_led = 1'b1;
    read_expect(reg_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_LED_OFS), 32'h0000_00A5, 1'b0);
    read_expect(reg_addr(rp_bus_pkg::REG_HK, 20'h10), 32'd0, 1'b1);  // unmapped
    read_expect(reg_addr(rp_bus_pkg::REG_SCOPE, 20'h0), 32'd0, 1'b0);
    test_done(2, "led, error and empty region");

    adc_run = 1'b1;
    write_reg(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_SRC_A_OFS),
              32'(rp_analog_pkg::SRC_ADC_A));
    wait_cycles(4);
    chk_pass = 1'b1;
    wait_cycles(40);
    chk_pass = 1'b0;
    test_done(3, "adc to dac pass-through");

    ofs_a = 8000;
    ofs_b = -8000;
    write_reg(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_SRC_B_OFS),
              32'(rp_analog_pkg::SRC_ADC_B));
    write_reg(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_OFS_A_OFS), 32'(ofs_a));
    write_reg(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_OFS_B_OFS), 32'(ofs_b));
    wait_cycles(4);
    chk_sat = 1'b1;
    wait_cycles(60);
    chk_sat = 1'b0;
    test_done(4, "saturating offset");

    write_reg(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_SRC_A_OFS),
              32'(rp_analog_pkg::SRC_CONST));
    write_reg(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_OFS_A_OFS), 32'(k_val));
    write_reg(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_SRC_B_OFS),
              32'(rp_analog_pkg::SRC_ADC_A));
    write_reg(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_OFS_B_OFS), 32'd0);
    write_reg(reg_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_LOOP_OFS), 32'd1);
    wait_cycles(2);  // checked from 4 cycles after loop on
    chk_loop = 1'b1;
    wait_cycles(30);
    chk_loop = 1'b0;
    test_done(5, "digital loop");

    write_reg(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_OFS_B_OFS), 32'(-8000));
    read_expect(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_SRC_A_OFS),
                32'(rp_analog_pkg::SRC_CONST), 1'b0);
    read_expect(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_SRC_B_OFS),
                32'(rp_analog_pkg::SRC_ADC_A), 1'b0);
    read_expect(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_OFS_A_OFS), 32'(k_val), 1'b0);
    read_expect(reg_addr(rp_bus_pkg::REG_DSP, rp_bus_pkg::RT_OFS_B_OFS), 32'(-8000), 1'b0);
    test_done(6, "router read-back");

    $display("summary: 6 tests, %0d failed checks, %0d bus timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: design/rp_top.sv
// single clock top; ADC pins to DAC pins is 3 cycles, only regions 0 and 3 hold registers
`timescale 1ns/1ps

module rp_top (
  input  logic                              adc_clk,
  input  logic                              rst_i,
  // register bus
  input  logic [rp_bus_pkg::BUS_AW-1:0]     sys_addr_i,
  input  logic [rp_bus_pkg::BUS_DW-1:0]     sys_wdata_i,
  input  logic                              sys_wen_i,
  input  logic                              sys_ren_i,
  output logic [rp_bus_pkg::BUS_DW-1:0]     sys_rdata_o,
  output logic                              sys_ack_o,
  output logic                              sys_err_o,
  // converters
  input  logic [rp_analog_pkg::SMP_W-1:0]   adc_dat_a_i,
  input  logic [rp_analog_pkg::SMP_W-1:0]   adc_dat_b_i,
  output logic [rp_analog_pkg::SMP_W-1:0]   dac_dat_a_o,
  output logic [rp_analog_pkg::SMP_W-1:0]   dac_dat_b_o,
  output logic [7:0]                        led_o
);

  // per slave bus wires
  logic                          hk_wen, hk_ren, hk_ack, hk_err;
  logic                          rt_wen, rt_ren, rt_ack, rt_err;
  logic [rp_bus_pkg::BUS_DW-1:0] hk_rdata, rt_rdata;

  // sample path
  logic signed [rp_analog_pkg::SMP_W-1:0] adc_a, adc_b;  // to router
  logic signed [rp_analog_pkg::SMP_W-1:0] out_a, out_b;  // to dac + loop
  logic                                   digital_loop;

  sys_bus_decoder i_dec (
    .adc_clk     (adc_clk),     .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),  .sys_wen_i   (sys_wen_i),   .sys_ren_i (sys_ren_i),
    .hk_rdata_i  (hk_rdata),    .hk_ack_i    (hk_ack),      .hk_err_i  (hk_err),
    .rt_rdata_i  (rt_rdata),    .rt_ack_i    (rt_ack),      .rt_err_i  (rt_err),
    .hk_wen_o    (hk_wen),      .hk_ren_o    (hk_ren),
    .rt_wen_o    (rt_wen),      .rt_ren_o    (rt_ren),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o   (sys_ack_o),   .sys_err_o (sys_err_o)
  );

  housekeeping i_hk (
    .adc_clk        (adc_clk),      .rst_i   (rst_i),
    .addr_i         (sys_addr_i[rp_bus_pkg::REGION_LSB-1:0]),
    .wdata_i        (sys_wdata_i),  .wen_i   (hk_wen),  .ren_i (hk_ren),
    .rdata_o        (hk_rdata),     .ack_o   (hk_ack),  .err_o (hk_err),
    .led_o          (led_o),
    .digital_loop_o (digital_loop)
  );

  adc_frontend i_adc (
    .adc_clk        (adc_clk),      .rst_i       (rst_i),
    .adc_dat_a_i    (adc_dat_a_i),  .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (out_a),        .loop_b_i    (out_b),   // loopback, unregistered
    .adc_a_o        (adc_a),        .adc_b_o     (adc_b)
  );

  output_router i_rt (
    .adc_clk (adc_clk),     .rst_i   (rst_i),
    .addr_i  (sys_addr_i[rp_bus_pkg::REGION_LSB-1:0]),
    .wdata_i (sys_wdata_i), .wen_i   (rt_wen),  .ren_i (rt_ren),
    .adc_a_i (adc_a),       .adc_b_i (adc_b),
    .rdata_o (rt_rdata),    .ack_o   (rt_ack),  .err_o (rt_err),
    .out_a_o (out_a),       .out_b_o (out_b)
  );

  dac_backend i_dac (
    .adc_clk     (adc_clk),      .rst_i       (rst_i),
    .dac_a_i     (out_a),        .dac_b_i     (out_b),
    .dac_dat_a_o (dac_dat_a_o),  .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

// File: design/dac_backend.sv
// two parallel DAC channels, no interleave; output register shows zero code in reset
`timescale 1ns/1ps

module dac_backend (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  input  logic signed [rp_analog_pkg::SMP_W-1:0] dac_a_i,
  input  logic signed [rp_analog_pkg::SMP_W-1:0] dac_b_i,
  output logic        [rp_analog_pkg::SMP_W-1:0] dac_dat_a_o,
  output logic        [rp_analog_pkg::SMP_W-1:0] dac_dat_b_o
);

  // two's complement -> neg-slope offset code, then out
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_dat_a_o <= rp_analog_pkg::ZERO_CODE;  // mid scale
      dac_dat_b_o <= rp_analog_pkg::ZERO_CODE;
    end
    else
    begin
      dac_dat_a_o <= dac_a_i ^ rp_analog_pkg::CONV_MASK;  // msb kept
      dac_dat_b_o <= dac_b_i ^ rp_analog_pkg::CONV_MASK;
    end
  end

endmodule

// File: design/output_router.sv
// region 3 slave; per channel src select + offset, sum clamped to 14 bits, 1 cycle latency
`timescale 1ns/1ps

module output_router (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  input  logic        [rp_bus_pkg::REGION_LSB-1:0] addr_i,
  input  logic        [rp_bus_pkg::BUS_DW-1:0]   wdata_i,
  input  logic                                   wen_i,
  input  logic                                   ren_i,
  input  logic signed [rp_analog_pkg::SMP_W-1:0] adc_a_i,
  input  logic signed [rp_analog_pkg::SMP_W-1:0] adc_b_i,
  output logic        [rp_bus_pkg::BUS_DW-1:0]   rdata_o,
  output logic                                   ack_o,
  output logic                                   err_o,
  output logic signed [rp_analog_pkg::SMP_W-1:0] out_a_o,
  output logic signed [rp_analog_pkg::SMP_W-1:0] out_b_o
);

  rp_analog_pkg::src_e                    src_a_q;
  rp_analog_pkg::src_e                    src_b_q;
  logic signed [rp_analog_pkg::SMP_W-1:0] ofs_a_q;
  logic signed [rp_analog_pkg::SMP_W-1:0] ofs_b_q;
  logic                                   ofs_ok;

  // pick source, add offset, clamp
  function automatic logic signed [rp_analog_pkg::SMP_W-1:0] route(
    input rp_analog_pkg::src_e                    src,
    input logic signed [rp_analog_pkg::SMP_W-1:0] a,
    input logic signed [rp_analog_pkg::SMP_W-1:0] b,
    input logic signed [rp_analog_pkg::SMP_W-1:0] ofs
  );
    logic signed [rp_analog_pkg::SMP_W-1:0] pick;
    logic signed [rp_analog_pkg::SMP_W:0]   sum;   // one guard bit
    logic signed [rp_analog_pkg::SMP_W-1:0] res;
    case (src)
      rp_analog_pkg::SRC_ADC_A: pick = a;
      rp_analog_pkg::SRC_ADC_B: pick = b;
      default:                  pick = '0;  // const gives offset only
    endcase
    sum = {pick[rp_analog_pkg::SMP_W-1], pick} + {ofs[rp_analog_pkg::SMP_W-1], ofs};
    if (src == rp_analog_pkg::SRC_OFF)
      res = '0;
    else if (sum > rp_analog_pkg::SMP_MAX)
      res = rp_analog_pkg::SMP_MAX;
    else if (sum < rp_analog_pkg::SMP_MIN)
      res = rp_analog_pkg::SMP_MIN;
    else
      res = sum[rp_analog_pkg::SMP_W-1:0];
    return res;
  endfunction

  assign ofs_ok = (addr_i == rp_bus_pkg::RT_SRC_A_OFS) || (addr_i == rp_bus_pkg::RT_SRC_B_OFS) ||
                  (addr_i == rp_bus_pkg::RT_OFS_A_OFS) || (addr_i == rp_bus_pkg::RT_OFS_B_OFS);

  //////////////////////////////
  // config registers
  //////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      src_a_q <= rp_analog_pkg::SRC_OFF;
      src_b_q <= rp_analog_pkg::SRC_OFF;
      ofs_a_q <= '0;
      ofs_b_q <= '0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      err_o <= (wen_i | ren_i) & ~ofs_ok;  // unmapped offset
      if (wen_i)
      begin
        case (addr_i)
          rp_bus_pkg::RT_SRC_A_OFS: src_a_q <= rp_analog_pkg::src_e'(wdata_i[1:0]);
          rp_bus_pkg::RT_SRC_B_OFS: src_b_q <= rp_analog_pkg::src_e'(wdata_i[1:0]);
          rp_bus_pkg::RT_OFS_A_OFS: ofs_a_q <= wdata_i[rp_analog_pkg::SMP_W-1:0];
          rp_bus_pkg::RT_OFS_B_OFS: ofs_b_q <= wdata_i[rp_analog_pkg::SMP_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // read back; offsets sign-extended
  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      case (addr_i)
        rp_bus_pkg::RT_SRC_A_OFS: rdata_o <= {{(rp_bus_pkg::BUS_DW-2){1'b0}}, src_a_q};
        rp_bus_pkg::RT_SRC_B_OFS: rdata_o <= {{(rp_bus_pkg::BUS_DW-2){1'b0}}, src_b_q};
        rp_bus_pkg::RT_OFS_A_OFS: rdata_o <= 32'(ofs_a_q);
        rp_bus_pkg::RT_OFS_B_OFS: rdata_o <= 32'(ofs_b_q);
        default:                  rdata_o <= '0;
      endcase
    end
  end

  //////////////////////////////
  // sample path
  //////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      out_a_o <= '0;  // loop starts from zero
      out_b_o <= '0;
    end
    else
    begin
      out_a_o <= route(src_a_q, adc_a_i, adc_b_i, ofs_a_q);
      out_b_o <= route(src_b_q, adc_a_i, adc_b_i, ofs_b_q);
    end
  end

  // a source write must carry a plain src_e code so nothing is cut off when stored
  a_src_legal: assert property (@(posedge adc_clk) disable iff (rst_i)
    (wen_i && (addr_i == rp_bus_pkg::RT_SRC_A_OFS || addr_i == rp_bus_pkg::RT_SRC_B_OFS))
    |-> (wdata_i[rp_bus_pkg::BUS_DW-1:2] == '0))
    else $error("router source write outside src_e range");

endmodule

// File: design/adc_frontend.sv
// pins registered once; loop path is combinational, so router out feeds back in one cycle
`timescale 1ns/1ps

module adc_frontend (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  input  logic        [rp_analog_pkg::SMP_W-1:0] adc_dat_a_i,
  input  logic        [rp_analog_pkg::SMP_W-1:0] adc_dat_b_i,
  input  logic                                   digital_loop_i,
  input  logic signed [rp_analog_pkg::SMP_W-1:0] loop_a_i,
  input  logic signed [rp_analog_pkg::SMP_W-1:0] loop_b_i,
  output logic signed [rp_analog_pkg::SMP_W-1:0] adc_a_o,
  output logic signed [rp_analog_pkg::SMP_W-1:0] adc_b_o
);

  logic [rp_analog_pkg::SMP_W-1:0] adc_dat_a;  // raw pin code
  logic [rp_analog_pkg::SMP_W-1:0] adc_dat_b;

  // input stage, starts at zero sample
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      adc_dat_a <= rp_analog_pkg::ZERO_CODE;
      adc_dat_b <= rp_analog_pkg::ZERO_CODE;
    end
    else
    begin
      adc_dat_a <= adc_dat_a_i;
      adc_dat_b <= adc_dat_b_i;
    end
  end

  // neg-slope offset -> two's complement, or loopback from router
  assign adc_a_o = digital_loop_i ? loop_a_i : $signed(adc_dat_a ^ rp_analog_pkg::CONV_MASK);
  assign adc_b_o = digital_loop_i ? loop_b_i : $signed(adc_dat_b ^ rp_analog_pkg::CONV_MASK);

endmodule

// File: design/housekeeping.sv
// region 0 slave; ack one cycle after strobe, full-word writes, ID writes silently dropped
`timescale 1ns/1ps

module housekeeping (
  input  logic                              adc_clk,
  input  logic                              rst_i,
  input  logic [rp_bus_pkg::REGION_LSB-1:0] addr_i,
  input  logic [rp_bus_pkg::BUS_DW-1:0]     wdata_i,
  input  logic                              wen_i,
  input  logic                              ren_i,
  output logic [rp_bus_pkg::BUS_DW-1:0]     rdata_o,
  output logic                              ack_o,
  output logic                              err_o,
  output logic [7:0]                        led_o,
  output logic                              digital_loop_o
);

  logic ofs_ok;  // offset is in the map

  assign ofs_ok = (addr_i == rp_bus_pkg::HK_ID_OFS)  ||
                  (addr_i == rp_bus_pkg::HK_LED_OFS) ||
                  (addr_i == rp_bus_pkg::HK_LOOP_OFS);

  //////////////////////////////
  // control registers + handshake
  //////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_o          <= 1'b0;
      err_o          <= 1'b0;
      led_o          <= 8'h00;
      digital_loop_o <= 1'b0;  // loop off after reset
    end
    else
    begin
      ack_o <= wen_i | ren_i;               // one-cycle pulse per strobe
      err_o <= (wen_i | ren_i) & ~ofs_ok;
      if (wen_i)
      begin
        case (addr_i)
          rp_bus_pkg::HK_LED_OFS:  led_o          <= wdata_i[7:0];
          rp_bus_pkg::HK_LOOP_OFS: digital_loop_o <= wdata_i[0];
          default: ;  // id or unmapped
        endcase
      end
    end
  end

  // read data, valid with ack
  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      case (addr_i)
        rp_bus_pkg::HK_ID_OFS:   rdata_o <= rp_bus_pkg::HK_ID_VALUE;
        rp_bus_pkg::HK_LED_OFS:  rdata_o <= {{(rp_bus_pkg::BUS_DW-8){1'b0}}, led_o};
        rp_bus_pkg::HK_LOOP_OFS: rdata_o <= {{(rp_bus_pkg::BUS_DW-1){1'b0}}, digital_loop_o};
        default:                 rdata_o <= '0;
      endcase
    end
  end

  // holds only while the master waits for each ack
  a_ack_pulse: assert property (@(posedge adc_clk) disable iff (rst_i)
    ack_o |=> !ack_o)
    else $error("housekeeping ack high two cycles");

endmodule

// File: design/sys_bus_decoder.sv
// slave answers must come exactly one cycle after the strobe; no new strobe before the ack
`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic                          adc_clk,
  input  logic                          rst_i,
  input  logic [rp_bus_pkg::BUS_AW-1:0] sys_addr_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  input  logic [rp_bus_pkg::BUS_DW-1:0] hk_rdata_i,
  input  logic                          hk_ack_i,
  input  logic                          hk_err_i,
  input  logic [rp_bus_pkg::BUS_DW-1:0] rt_rdata_i,
  input  logic                          rt_ack_i,
  input  logic                          rt_err_i,
  output logic                          hk_wen_o,
  output logic                          hk_ren_o,
  output logic                          rt_wen_o,
  output logic                          rt_ren_o,
  output logic [rp_bus_pkg::BUS_DW-1:0] sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o
);

  rp_bus_pkg::region_e                  region;    // region of this strobe
  rp_bus_pkg::region_e                  region_q;  // region owed an answer
  logic [rp_bus_pkg::NUM_REGIONS-1:0]   cs;        // one-hot chip select
  logic                                 strobe;
  logic                                 spare_hit; // strobe into a slave-less region

  assign region = rp_bus_pkg::region_e'(sys_addr_i[rp_bus_pkg::REGION_MSB:rp_bus_pkg::REGION_LSB]);
  assign cs     = {{(rp_bus_pkg::NUM_REGIONS-1){1'b0}}, 1'b1} << region;
  assign strobe = sys_wen_i | sys_ren_i;

  // strobe fan-out, only the hit slave sees it
  assign hk_wen_o = sys_wen_i & cs[rp_bus_pkg::REG_HK];
  assign hk_ren_o = sys_ren_i & cs[rp_bus_pkg::REG_HK];
  assign rt_wen_o = sys_wen_i & cs[rp_bus_pkg::REG_DSP];
  assign rt_ren_o = sys_ren_i & cs[rp_bus_pkg::REG_DSP];

  assign spare_hit = strobe & ~cs[rp_bus_pkg::REG_HK] & ~cs[rp_bus_pkg::REG_DSP];

  // remember who was addressed, the ack shows up next cycle
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      region_q <= rp_bus_pkg::REG_HK;
    else if (strobe)
      region_q <= region;
  end

  //////////////////////////////
  // read-back mux
  //////////////////////////////
  always_comb
  begin
    sys_rdata_o = '0;
    sys_ack_o   = 1'b0;
    sys_err_o   = 1'b0;
    if (spare_hit)
      sys_ack_o = 1'b1;  // empty region, answer now with zero
    else
    begin
      case (region_q)
        rp_bus_pkg::REG_HK:
        begin
          sys_rdata_o = hk_rdata_i;
          sys_ack_o   = hk_ack_i;
          sys_err_o   = hk_err_i;
        end
        rp_bus_pkg::REG_DSP:
        begin
          sys_rdata_o = rt_rdata_i;
          sys_ack_o   = rt_ack_i;
          sys_err_o   = rt_err_i;
        end
        default: ;  // nothing pending
      endcase
    end
  end

  // master side rule
  a_no_dual_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(sys_wen_i && sys_ren_i))
    else $error("write and read strobe together");

  // slaves must answer on the next edge
  a_slave_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    (strobe && !spare_hit) |=> sys_ack_o)
    else $error("slave ack missing one cycle after strobe");

endmodule

// File: design/rp_analog_pkg.sv
// sample format: 14-bit two's complement inside, 14-bit negative-slope offset code on pins
package rp_analog_pkg;

  localparam int SMP_W = 14;

  // clamp limits of the router sum
  localparam logic signed [SMP_W-1:0] SMP_MAX = 14'sh1FFF;  // +8191
  localparam logic signed [SMP_W-1:0] SMP_MIN = 14'sh2000;  // -8192

  // keep msb, flip the rest; same mask works in both directions
  localparam logic [SMP_W-1:0] CONV_MASK = 14'h1FFF;
  // pin code of a zero sample
  localparam logic [SMP_W-1:0] ZERO_CODE = 14'h1FFF;

  // router source select
  typedef enum logic [1:0] {
    SRC_OFF   = 2'd0,  // output forced to zero
    SRC_ADC_A = 2'd1,
    SRC_ADC_B = 2'd2,
    SRC_CONST = 2'd3   // offset alone
  } src_e;

endpackage

// File: design/rp_bus_pkg.sv
// register bus constants; full-word access only, 8 regions on addr[22:20], 20-bit offsets
package rp_bus_pkg;

  //////////////////////////////
  // bus geometry
  //////////////////////////////
  localparam int BUS_AW      = 32;
  localparam int BUS_DW      = 32;
  localparam int REGION_LSB  = 20;  // lowest region bit, also offset width
  localparam int REGION_MSB  = 22;
  localparam int NUM_REGIONS = 8;

  // region numbers, only hk and dsp carry a slave
  typedef enum logic [2:0] {
    REG_HK     = 3'd0,
    REG_SCOPE  = 3'd1,
    REG_ASG    = 3'd2,
    REG_DSP    = 3'd3,
    REG_AMS    = 3'd4,
    REG_SPARE5 = 3'd5,
    REG_SPARE6 = 3'd6,
    REG_SPARE7 = 3'd7
  } region_e;

  //////////////////////////////
  // register map
  //////////////////////////////
  localparam logic [REGION_LSB-1:0] HK_ID_OFS    = 20'h00;  // read only
  localparam logic [REGION_LSB-1:0] HK_LED_OFS   = 20'h04;
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS  = 20'h08;  // bit 0 only
  localparam logic [REGION_LSB-1:0] RT_SRC_A_OFS = 20'h00;
  localparam logic [REGION_LSB-1:0] RT_SRC_B_OFS = 20'h04;
  localparam logic [REGION_LSB-1:0] RT_OFS_A_OFS = 20'h08;
  localparam logic [REGION_LSB-1:0] RT_OFS_B_OFS = 20'h0C;

  localparam logic [BUS_DW-1:0] HK_ID_VALUE = 32'h5250_0001;  // board id + revision

endpackage
